// File: project.f
source/adc_seek_pkg.sv
source/lane_ramp_checker.sv
source/tap_window_register.sv
source/seek_sequencer.sv
source/adc_seek_top.sv
verification/adc_seek_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ADC eye search simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module adc_seek_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vadc_seek_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: source/adc_seek_pkg.sv
package adc_seek_pkg;

    ////////////////////
    // frame geometry
    ////////////////////
    localparam int SAMPLE_W         = 10;
    localparam int SAMPLES_PER_LANE = 8;
    localparam int LANE_NUM         = 4;

    // test pattern is a ramp, +8 per clock on every sample
    localparam logic [SAMPLE_W-1:0] RAMP_STEP = 10'd8;

    // input delay line
    localparam int TAP_W = 9;
    localparam logic [TAP_W-1:0] TAP_MAX = 9'd511;

    ////////////////////
    // sequencer timing, clk_div cycles
    ////////////////////
    localparam int CNT_W = 16;
    localparam logic [CNT_W-1:0] DETECT_WORDS   = 16'd64;
    localparam logic [CNT_W-1:0] CLEAR_LEN      = 16'd2;
    localparam logic [CNT_W-1:0] IODELAY_SETTLE = 16'd32;
    localparam logic [CNT_W-1:0] SERDES_SETTLE  = 16'd16;
    localparam logic [CNT_W-1:0] ADC_RST_LEN    = 16'd10;

    ////////////////////
    // types
    ////////////////////
    typedef logic [SAMPLES_PER_LANE*SAMPLE_W-1:0] lane_word_t;

    typedef struct packed {
        lane_word_t a;
        lane_word_t b;
        lane_word_t c;
        lane_word_t d;
    } adc_frame_t;

    typedef logic [TAP_W-1:0] tap_t;

    typedef struct packed {
        tap_t first_tap;
        tap_t end_tap;
        logic first_valid;
        logic end_valid;
    } win_result_t;

    typedef struct packed {
        logic iodelay_rst;
        logic spi_rstn;
        logic test_mode;
    } seek_ctrl_t;

    // one-cycle strobes to the tap register
    typedef struct packed {
        logic tap_clear;
        logic tap_step;
        logic mark_first;
        logic mark_end;
        logic load_center;
    } tap_cmd_t;

    typedef enum logic [3:0] {
        IDLE,
        ADC_CONFIG,
        TAP_LOAD,
        TAP_SETTLE,
        LOCK_WAIT,
        DETECT,
        DECIDE,
        CENTER_LOAD,
        CENTER_SETTLE,
        ADC_RESET,
        ADC_WAIT,
        NORMAL
    } seek_state_t;

endpackage

// File: source/adc_seek_top.sv
`timescale 1ns/10ps

module adc_seek_top
(
    input  logic                       clk_div,
    input  logic                       en_buf_adc_data,
    input  logic                       sd_locked,
    input  logic                       adc_ready,
    input  adc_seek_pkg::adc_frame_t   adc_data,
    output adc_seek_pkg::tap_t         tap_value,
    output adc_seek_pkg::seek_ctrl_t   ctrl,
    output logic                       win_ok_all,
    output adc_seek_pkg::win_result_t  window,
    output adc_seek_pkg::seek_state_t  seek_state
);

    adc_seek_pkg::lane_word_t [adc_seek_pkg::LANE_NUM-1:0]  lane_words;
    logic [adc_seek_pkg::LANE_NUM-1:0]                      lane_error;
    logic                                                   ramp_error;
    logic                                                   check_clear;
    logic                                                   last_tap;
    adc_seek_pkg::tap_cmd_t                                 tap_cmd;

    // lane d at index 0, lane a at the top
    assign lane_words = adc_data;
    assign ramp_error = |lane_error;

    for (genvar l = 0; l < adc_seek_pkg::LANE_NUM; l++)
    begin : g_lane
        lane_ramp_checker i_checker
        (
            .clk_div         (clk_div),
            .en_buf_adc_data (en_buf_adc_data),
            .lane_in         (lane_words[l]),
            .check_clear     (check_clear),
            .lane_error      (lane_error[l])
        );
    end

    tap_window_register i_tap_reg
    (
        .clk_div         (clk_div),
        .en_buf_adc_data (en_buf_adc_data),
        .cmd             (tap_cmd),
        .last_tap        (last_tap),
        .tap             (tap_value),
        .result          (window)
    );

    seek_sequencer i_seq
    (
        .clk_div         (clk_div),
        .en_buf_adc_data (en_buf_adc_data),
        .sd_locked       (sd_locked),
        .adc_ready       (adc_ready),
        .ramp_error      (ramp_error),
        .tap             (tap_value),
        .result          (window),
        .cmd             (tap_cmd),
        .last_tap        (last_tap),
        .check_clear     (check_clear),
        .ctrl            (ctrl),
        .win_ok_all      (win_ok_all),
        .state           (seek_state)
    );

endmodule

// File: source/lane_ramp_checker.sv
`timescale 1ns/10ps

module lane_ramp_checker
(
    input  logic                      clk_div,
    input  logic                      en_buf_adc_data,
    input  adc_seek_pkg::lane_word_t  lane_in,
    input  logic                      check_clear,
    output logic                      lane_error
);

    adc_seek_pkg::lane_word_t                   prev_word;
    logic [adc_seek_pkg::SAMPLES_PER_LANE-1:0]  mismatch;
    logic [adc_seek_pkg::SAMPLES_PER_LANE-1:0]  err_flag;

    // previous word keeps updating during a clear too
    always_ff @(posedge clk_div or posedge en_buf_adc_data)
    begin
        if (en_buf_adc_data)
            prev_word <= '0;
        else
            prev_word <= lane_in;
    end

    for (genvar i = 0; i < adc_seek_pkg::SAMPLES_PER_LANE; i++)
    begin : g_sample
        logic [adc_seek_pkg::SAMPLE_W-1:0] expected;

        // wraps modulo 1024
        assign expected = prev_word[i*adc_seek_pkg::SAMPLE_W +: adc_seek_pkg::SAMPLE_W]
                          + adc_seek_pkg::RAMP_STEP;
        assign mismatch[i] =
            (lane_in[i*adc_seek_pkg::SAMPLE_W +: adc_seek_pkg::SAMPLE_W] != expected);
    end

    // sticky per sample until the sequencer clears
    always_ff @(posedge clk_div or posedge en_buf_adc_data)
    begin
        if (en_buf_adc_data)
            err_flag <= '0;
        else if (check_clear)
            err_flag <= '0;
        else
            err_flag <= err_flag | mismatch;
    end

    assign lane_error = |err_flag;

endmodule

// File: source/seek_sequencer.sv
`timescale 1ns/10ps

module seek_sequencer
(
    input  logic                       clk_div,
    input  logic                       en_buf_adc_data,
    input  logic                       sd_locked,
    input  logic                       adc_ready,
    input  logic                       ramp_error,
    input  adc_seek_pkg::tap_t         tap,
    input  adc_seek_pkg::win_result_t  result,
    output adc_seek_pkg::tap_cmd_t     cmd,
    output logic                       last_tap,
    output logic                       check_clear,
    output adc_seek_pkg::seek_ctrl_t   ctrl,
    output logic                       win_ok_all,
    output adc_seek_pkg::seek_state_t  state
);

    adc_seek_pkg::seek_state_t       state_nxt;
    adc_seek_pkg::seek_ctrl_t        ctrl_nxt;
    logic [adc_seek_pkg::CNT_W-1:0]  cnt;
    logic [adc_seek_pkg::CNT_W-1:0]  cnt_nxt;
    logic                            det_pass;
    logic                            det_pass_nxt;
    logic                            at_max;
    logic                            clean_done;

    assign at_max     = (tap == adc_seek_pkg::TAP_MAX);
    assign clean_done = (cnt == adc_seek_pkg::CLEAR_LEN + adc_seek_pkg::DETECT_WORDS - 1'b1);

    // checkers held clear outside DETECT and for its first cycles
    assign check_clear = (state != adc_seek_pkg::DETECT) || (cnt < adc_seek_pkg::CLEAR_LEN);

    ////////////////////
    // next state
    ////////////////////
    always_comb
    begin
        state_nxt    = state;
        cnt_nxt      = cnt;
        det_pass_nxt = det_pass;
        cmd          = '0;
        case (state)
            adc_seek_pkg::IDLE:
            begin
                cnt_nxt = '0;
                if (sd_locked)
                    state_nxt = adc_seek_pkg::ADC_CONFIG;
            end
            adc_seek_pkg::ADC_CONFIG:
            begin
                if (adc_ready)
                    state_nxt = adc_seek_pkg::TAP_LOAD;
            end
            adc_seek_pkg::TAP_LOAD:
            begin
                cnt_nxt   = '0;
                state_nxt = adc_seek_pkg::TAP_SETTLE;
            end
            adc_seek_pkg::TAP_SETTLE:
            begin
                cnt_nxt = cnt + 1'b1;
                if (cnt == adc_seek_pkg::IODELAY_SETTLE - 1'b1)
                begin
                    cnt_nxt   = '0;
                    state_nxt = adc_seek_pkg::LOCK_WAIT;
                end
            end
            adc_seek_pkg::LOCK_WAIT:
            begin
                // counter stays at zero until lock is seen
                if (cnt != '0 || sd_locked)
                    cnt_nxt = cnt + 1'b1;
                if (cnt == adc_seek_pkg::SERDES_SETTLE)
                begin
                    cnt_nxt   = '0;
                    state_nxt = adc_seek_pkg::DETECT;
                end
            end
            adc_seek_pkg::DETECT:
            begin
                cnt_nxt = cnt + 1'b1;
                if (cnt >= adc_seek_pkg::CLEAR_LEN && (ramp_error || clean_done))
                begin
                    det_pass_nxt = !ramp_error;
                    cnt_nxt      = '0;
                    state_nxt    = adc_seek_pkg::DECIDE;
                end
            end
            adc_seek_pkg::DECIDE:
            begin
                cnt_nxt = '0;
                if (det_pass && !result.first_valid)
                begin
                    cmd.mark_first = 1'b1;
                    cmd.mark_end   = at_max;
                    cmd.tap_step   = !at_max;
                    state_nxt = at_max ? adc_seek_pkg::CENTER_LOAD : adc_seek_pkg::TAP_LOAD;
                end
                else if (!det_pass && result.first_valid)
                begin
                    cmd.mark_end = 1'b1;
                    state_nxt    = adc_seek_pkg::CENTER_LOAD;
                end
                else if (!at_max)
                begin
                    cmd.tap_step = 1'b1;
                    state_nxt    = adc_seek_pkg::TAP_LOAD;
                end
                else if (det_pass)
                begin
                    cmd.mark_end = 1'b1;
                    state_nxt    = adc_seek_pkg::CENTER_LOAD;
                end
                else
                begin
                    // whole sweep failed, start over
                    cmd.tap_clear = 1'b1;
                    state_nxt     = adc_seek_pkg::IDLE;
                end
            end
            adc_seek_pkg::CENTER_LOAD:
            begin
                cmd.load_center = 1'b1;
                cnt_nxt         = '0;
                state_nxt       = adc_seek_pkg::CENTER_SETTLE;
            end
            adc_seek_pkg::CENTER_SETTLE:
            begin
                cnt_nxt = cnt + 1'b1;
                if (cnt == adc_seek_pkg::IODELAY_SETTLE - 1'b1)
                begin
                    cnt_nxt   = '0;
                    state_nxt = adc_seek_pkg::ADC_RESET;
                end
            end
            adc_seek_pkg::ADC_RESET:
            begin
                cnt_nxt = cnt + 1'b1;
                if (cnt == adc_seek_pkg::ADC_RST_LEN - 1'b1)
                begin
                    cnt_nxt   = '0;
                    state_nxt = adc_seek_pkg::ADC_WAIT;
                end
            end
            adc_seek_pkg::ADC_WAIT:
            begin
                if (adc_ready)
                    state_nxt = adc_seek_pkg::NORMAL;
            end
            adc_seek_pkg::NORMAL:
            begin
                state_nxt = adc_seek_pkg::NORMAL;
            end
            default:
            begin
                state_nxt = adc_seek_pkg::IDLE;
            end
        endcase
    end

    // control levels per state, registered below
    always_comb
    begin
        ctrl_nxt.iodelay_rst = (state == adc_seek_pkg::IDLE) ||
                               (state == adc_seek_pkg::TAP_LOAD) ||
                               (state == adc_seek_pkg::CENTER_LOAD);
        ctrl_nxt.spi_rstn    = (state != adc_seek_pkg::IDLE) &&
                               (state != adc_seek_pkg::ADC_RESET);
        ctrl_nxt.test_mode   = !(state inside {adc_seek_pkg::ADC_RESET,
                                               adc_seek_pkg::ADC_WAIT,
                                               adc_seek_pkg::NORMAL});
    end

    ////////////////////
    // registers
    ////////////////////
    always_ff @(posedge clk_div or posedge en_buf_adc_data)
    begin
        if (en_buf_adc_data)
        begin
            state      <= adc_seek_pkg::IDLE;
            cnt        <= '0;
            det_pass   <= 1'b0;
            last_tap   <= 1'b0;
            ctrl       <= '{iodelay_rst: 1'b1, spi_rstn: 1'b0, test_mode: 1'b1};
            win_ok_all <= 1'b0;
        end
        else
        begin
            state    <= state_nxt;
            cnt      <= cnt_nxt;
            det_pass <= det_pass_nxt;
            // one cycle behind the state, so a load pulse sees the tap already updated
            ctrl     <= ctrl_nxt;
            win_ok_all <= win_ok_all | (state == adc_seek_pkg::NORMAL);
            // set only when the last tap itself passed
            if (state == adc_seek_pkg::DETECT)
                last_tap <= at_max && !ramp_error;
        end
    end

endmodule

// File: source/tap_window_register.sv
`timescale 1ns/10ps

module tap_window_register
(
    input  logic                       clk_div,
    input  logic                       en_buf_adc_data,
    input  adc_seek_pkg::tap_cmd_t     cmd,
    input  logic                       last_tap,
    output adc_seek_pkg::tap_t         tap,
    output adc_seek_pkg::win_result_t  result
);

    logic [adc_seek_pkg::TAP_W:0]  center_sum;
    adc_seek_pkg::tap_t            end_value;

    // one extra bit so 511 + 511 does not wrap
    assign center_sum = {1'b0, result.first_tap} + {1'b0, result.end_tap};

    // window closed at the previous tap, unless the sweep ran out while passing
    assign end_value = last_tap ? tap : tap - 1'b1;

    ////////////////////
    // tap under sweep
    ////////////////////
    always_ff @(posedge clk_div or posedge en_buf_adc_data)
    begin
        if (en_buf_adc_data)
        begin
            tap <= '0;
        end
        else if (cmd.tap_clear)
        begin
            tap <= '0;
        end
        else if (cmd.load_center)
        begin
            // floor of the average
            tap <= center_sum[adc_seek_pkg::TAP_W:1];
        end
        else if (cmd.tap_step)
        begin
            tap <= tap + 1'b1;
        end
    end

    ////////////////////
    // window edges
    ////////////////////
    always_ff @(posedge clk_div or posedge en_buf_adc_data)
    begin
        if (en_buf_adc_data)
        begin
            result <= '0;
        end
        else if (cmd.tap_clear)
        begin
            result <= '0;
        end
        else
        begin
            // both marks can land together at the last tap
            if (cmd.mark_first)
            begin
                result.first_tap   <= tap;
                result.first_valid <= 1'b1;
            end
            if (cmd.mark_end)
            begin
                result.end_tap   <= end_value;
                result.end_valid <= 1'b1;
            end
        end
    end

endmodule

// File: verification/adc_seek_tb.sv
`timescale 1ns/10ps

module adc_seek_tb;

    localparam int CLK_PERIOD = 100;
    localparam int TEST_NUM   = 5;
    localparam int SW         = adc_seek_pkg::SAMPLE_W;
    localparam int FRAME_W    = adc_seek_pkg::LANE_NUM * adc_seek_pkg::SAMPLES_PER_LANE * SW;

    // load, settle, lock, clear, clean words and decide for one passing tap
    localparam int TAP_CYCLES = 3 + int'(adc_seek_pkg::IODELAY_SETTLE)
                                  + int'(adc_seek_pkg::SERDES_SETTLE)
                                  + int'(adc_seek_pkg::CLEAR_LEN)
                                  + int'(adc_seek_pkg::DETECT_WORDS);
    localparam int SWEEP_CYCLES    = (int'(adc_seek_pkg::TAP_MAX) + 1) * TAP_CYCLES;
    localparam int WATCHDOG_CYCLES = TEST_NUM * SWEEP_CYCLES * 2;

    logic                       clk_div;
    logic                       en_buf_adc_data;
    logic                       sd_locked;
    logic                       adc_ready;
    adc_seek_pkg::adc_frame_t   adc_data;
    adc_seek_pkg::tap_t         tap_value;
    adc_seek_pkg::seek_ctrl_t   ctrl;
    logic                       win_ok_all;
    adc_seek_pkg::win_result_t  window;
    adc_seek_pkg::seek_state_t  seek_state;

    int                  error_count;
    int                  test_count;
    int                  win_lo;
    int                  win_hi;
    int                  bad_pos;
    logic                hold_ready;
    logic [3:0]          ready_pipe;
    logic [SW-1:0]       ramp_base;
    logic [SW-1:0]       bad_offset;
    logic [FRAME_W-1:0]  frame_bits;
    logic [31:0]         rnd;

    adc_seek_top i_dut
    (
        .clk_div         (clk_div),
        .en_buf_adc_data (en_buf_adc_data),
        .sd_locked       (sd_locked),
        .adc_ready       (adc_ready),
        .adc_data        (adc_data),
        .tap_value       (tap_value),
        .ctrl            (ctrl),
        .win_ok_all      (win_ok_all),
        .window          (window),
        .seek_state      (seek_state)
    );

    always
    begin
        #(CLK_PERIOD / 2);
        clk_div = ~clk_div;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////
    // ADC model
    ////////////////////
    always @(posedge clk_div)
    begin
        #10;
        ramp_base  = ramp_base + adc_seek_pkg::RAMP_STEP;
        // consecutive ramp values across lanes and samples
        for (int s = 0; s < FRAME_W / SW; s++)
            frame_bits[s*SW +: SW] = ramp_base + SW'(s);
        // eye closed outside the chosen window
        if (int'(tap_value) < win_lo || int'(tap_value) > win_hi)
        begin
            rnd        = xorshift(rnd);
            bad_offset = (rnd[SW-1:0] == '0) ? SW'(1) : rnd[SW-1:0];
            bad_pos    = int'(rnd[20:16]);
            frame_bits[bad_pos*SW +: SW] = frame_bits[bad_pos*SW +: SW] + bad_offset;
        end
        adc_data   = frame_bits;
        ready_pipe = {ready_pipe[2:0], ctrl.spi_rstn};
        adc_ready  = ready_pipe[3] && !hold_ready;
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error %s got %0h exp %0h", name, got, exp);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        $display("test %s done, %0d errors", name, error_count - start_errors);
    endtask

    task automatic apply_reset();
        @(posedge clk_div);
        #10;
        en_buf_adc_data = 1'b1;
        repeat (4) @(posedge clk_div);
        #10;
        en_buf_adc_data = 1'b0;
    endtask

    task automatic wait_win_ok(input int max_cycles, output logic seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < max_cycles)
        begin
            @(negedge clk_div);
            seen = win_ok_all;
            n++;
        end
    endtask

    task automatic check_reset_outputs();
        if (win_ok_all !== 1'b0)
            report_mismatch("win_ok_all", win_ok_all, 0);
        if (tap_value !== '0)
            report_mismatch("tap_value", tap_value, 0);
        if (window !== '0)
            report_mismatch("window", window, 0);
        if (ctrl.iodelay_rst !== 1'b1)
            report_mismatch("ctrl.iodelay_rst", ctrl.iodelay_rst, 1);
        if (ctrl.spi_rstn !== 1'b0)
            report_mismatch("ctrl.spi_rstn", ctrl.spi_rstn, 0);
        if (ctrl.test_mode !== 1'b1)
            report_mismatch("ctrl.test_mode", ctrl.test_mode, 1);
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic test_reset_state();
        int start_errors;
        start_errors = error_count;
        @(posedge clk_div);
        #10;
        en_buf_adc_data = 1'b1;
        repeat (3) @(posedge clk_div);
        @(negedge clk_div);
        check_reset_outputs();
        @(posedge clk_div);
        #10;
        en_buf_adc_data = 1'b0;
        // first edge after release
        @(posedge clk_div);
        @(negedge clk_div);
        check_reset_outputs();
        finish_test("reset_state", start_errors);
    endtask

    task automatic run_window_search(input string name, input int lo, input int hi);
        int   start_errors;
        int   center;
        logic seen;
        start_errors = error_count;
        win_lo       = lo;
        win_hi       = hi;
        center       = (lo + hi) / 2;
        apply_reset();
        wait_win_ok(SWEEP_CYCLES, seen);
        if (!seen)
            report_failure($sformatf("win_ok_all never rose for window %0d to %0d", lo, hi));
        if (window.first_tap !== adc_seek_pkg::tap_t'(lo))
            report_mismatch("window.first_tap", window.first_tap, lo);
        if (window.end_tap !== adc_seek_pkg::tap_t'(hi))
            report_mismatch("window.end_tap", window.end_tap, hi);
        if (window.first_valid !== 1'b1)
            report_mismatch("window.first_valid", window.first_valid, 1);
        if (window.end_valid !== 1'b1)
            report_mismatch("window.end_valid", window.end_valid, 1);
        if (tap_value !== adc_seek_pkg::tap_t'(center))
            report_mismatch("tap_value", tap_value, center);
        if (ctrl.test_mode !== 1'b0)
            report_mismatch("ctrl.test_mode", ctrl.test_mode, 0);
        finish_test(name, start_errors);
    endtask

    task automatic test_no_window();
        int   start_errors;
        int   n;
        logic hit_max;
        logic back_idle;
        logic ok_rose;
        start_errors = error_count;
        win_lo       = 1000;
        win_hi       = 1000;
        hit_max      = 1'b0;
        back_idle    = 1'b0;
        ok_rose      = 1'b0;
        n            = 0;
        apply_reset();
        while (!back_idle && n < SWEEP_CYCLES)
        begin
            @(negedge clk_div);
            n++;
            if (win_ok_all !== 1'b0 && !ok_rose)
            begin
                ok_rose = 1'b1;
                report_mismatch("win_ok_all", win_ok_all, 0);
            end
            if (tap_value == adc_seek_pkg::TAP_MAX)
                hit_max = 1'b1;
            else if (hit_max && tap_value == '0 && seek_state == adc_seek_pkg::IDLE)
                back_idle = 1'b1;
        end
        if (!hit_max)
            report_failure("tap_value never reached the last tap in the failing sweep");
        else if (!back_idle)
            report_failure("sequencer did not return to IDLE with tap 0 after the sweep");
        finish_test("no_window", start_errors);
    endtask

    task automatic test_final_reset();
        int   start_errors;
        int   n;
        int   low_cycles;
        logic seen;
        logic ok_rose;
        start_errors = error_count;
        win_lo       = 100;
        win_hi       = 180;
        ok_rose      = 1'b0;
        n            = 0;
        apply_reset();
        while (seek_state != adc_seek_pkg::ADC_RESET && n < SWEEP_CYCLES)
        begin
            @(negedge clk_div);
            n++;
        end
        if (seek_state != adc_seek_pkg::ADC_RESET)
        begin
            report_failure("sequencer never reached the final ADC reset");
        end
        else
        begin
            hold_ready = 1'b1;
            // ctrl lags the state by one cycle
            n = 0;
            while (ctrl.spi_rstn && n < 4)
            begin
                @(negedge clk_div);
                n++;
            end
            low_cycles = 0;
            while (!ctrl.spi_rstn && low_cycles < 4 * int'(adc_seek_pkg::ADC_RST_LEN))
            begin
                if (ctrl.test_mode !== 1'b0)
                    report_mismatch("ctrl.test_mode", ctrl.test_mode, 0);
                low_cycles++;
                @(negedge clk_div);
            end
            if (low_cycles != int'(adc_seek_pkg::ADC_RST_LEN))
                report_mismatch("spi_rstn low cycles", low_cycles, adc_seek_pkg::ADC_RST_LEN);
            repeat (50)
            begin
                @(negedge clk_div);
                if (win_ok_all !== 1'b0 && !ok_rose)
                begin
                    ok_rose = 1'b1;
                    report_mismatch("win_ok_all", win_ok_all, 0);
                end
            end
            hold_ready = 1'b0;
            wait_win_ok(20, seen);
            if (!seen)
                report_failure("win_ok_all did not rise after adc_ready was released");
        end
        finish_test("final_reset", start_errors);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        clk_div         = 1'b0;
        en_buf_adc_data = 1'b1;
        sd_locked       = 1'b0;
        adc_ready       = 1'b0;
        adc_data        = '0;
        error_count     = 0;
        test_count      = 0;
        win_lo          = 0;
        win_hi          = int'(adc_seek_pkg::TAP_MAX);
        hold_ready      = 1'b0;
        ready_pipe      = '0;
        ramp_base       = '0;
        rnd             = 32'h78ef_c47f;
        @(posedge clk_div);
        #10;
        sd_locked = 1'b1;

        test_reset_state();
        run_window_search("mid_window", 100, 180);
        run_window_search("last_tap_window", 470, 511);
        test_no_window();
        test_final_reset();

        $display("tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_div);
        $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule
